// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exec_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== exec_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exec_tb;

    localparam int RS_SIZE  = 8;
    localparam int NUM_ALU  = 2;
    localparam int NUM_MULT = 1;
    localparam int NUM_CDB  = NUM_ALU + NUM_MULT;
    localparam int CR_W     = $clog2(NUM_CDB + 1);
    localparam int TIMEOUT  = 2000;  // the six tests need roughly 600 cycles in the worst case

    logic                               clock;
    logic                               reset;
    ooo_pkg::dispatch_packet_t          dispatch;
    logic [CR_W-1:0]                    credit_return;
    ooo_pkg::cdb_packet_t [NUM_CDB-1:0] cdb;

    // scoreboard, indexed by destination tag
    ooo_pkg::data_t    exp_val  [64];
    ooo_pkg::robn_t    exp_robn [64];
    ooo_pkg::fu_type_e exp_fu   [64];
    bit                pending  [64];
    int                disp_cyc [64];
    int                arr_cyc  [64];
    int                arr_lane [64];
    ooo_pkg::prn_t     rob_tag  [32];  // destination tag handed out with each robn

    int             npending  = 0;
    int             returned  = 0;   // credits handed back by the station
    int             spent     = 0;
    int             cycle     = 0;
    int             errors    = 0;
    int             tests_ok  = 0;
    int             tests_bad = 0;
    integer         seed      = 32'h1d69;
    ooo_pkg::robn_t next_robn = '0;

    ooo_exec_top #(
        .RS_SIZE  (RS_SIZE),
        .NUM_ALU  (NUM_ALU),
        .NUM_MULT (NUM_MULT)
    ) UUT (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .credit_return (credit_return),
        .cdb           (cdb)
    );

    always #4 clock = ~clock;

    function automatic int available();
        return RS_SIZE + returned - spent;
    endfunction

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (reset) begin
            returned <= 0;
        end else begin
            returned <= returned + int'(credit_return);
        end
        if (cycle >= TIMEOUT) begin
            $display("run stopped at cycle %0d with %0d results still missing", cycle, npending);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("error at cycle %0d: %s", cycle, msg);
    endtask

    task automatic check_cdb(input string name, input ooo_pkg::cdb_packet_t got,
                             input ooo_pkg::data_t exp_value, input ooo_pkg::prn_t exp_prn,
                             input ooo_pkg::robn_t exp_rob);
        if (got.value !== exp_value) begin
            errors++;
            $display("[ERROR] %s.value got 0x%08h expected 0x%08h", name, got.value, exp_value);
        end
        if (got.dest_prn !== exp_prn || got.robn !== exp_rob) begin
            errors++;
            $display("[ERROR] %s tag/robn got 0x%02h/0x%02h expected 0x%02h/0x%02h",
                     name, got.dest_prn, got.robn, exp_prn, exp_rob);
        end
    endtask

    task automatic check_credits(input string name, input int got, input int expected);
        if (got != expected) begin
            errors++;
            $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic check_latency(input ooo_pkg::prn_t tag, input int expected);
        if (arr_cyc[tag] - disp_cyc[tag] != expected) begin
            errors++;
            $display("[ERROR] latency of tag 0x%02h got 0x%0h expected 0x%0h",
                     tag, arr_cyc[tag] - disp_cyc[tag], expected);
        end
    endtask

    // every broadcast has to retire a pending scoreboard entry on the right lane
    always @(negedge clock) begin
        ooo_pkg::prn_t tag;
        if (!reset) begin
            for (int l = 0; l < NUM_CDB; l++) begin
                if (cdb[l].valid) begin
                    tag = cdb[l].dest_prn;
                    if (!pending[tag]) begin
                        report_error($sformatf("tag %0d on lane %0d was not expected", tag, l));
                    end else begin
                        check_cdb($sformatf("cdb[%0d]", l), cdb[l], exp_val[tag],
                                  rob_tag[cdb[l].robn], exp_robn[tag]);
                        if ((exp_fu[tag] == ooo_pkg::FU_MULT) != (l >= NUM_ALU)) begin
                            report_error($sformatf("tag %0d came out on lane %0d", tag, l));
                        end
                        pending[tag]  = 1'b0;
                        npending--;
                        arr_cyc[tag]  = cycle;
                        arr_lane[tag] = l;
                    end
                end
            end
            if (available() > RS_SIZE) begin
                report_error("station returned more credits than were spent");
            end
        end
    end

    function automatic ooo_pkg::data_t expect_result(input ooo_pkg::fu_type_e fu,
            input ooo_pkg::alu_func_e func, input ooo_pkg::data_t a, input ooo_pkg::data_t b);
        if (fu == ooo_pkg::FU_MULT) begin
            return a * b;  // low half of the product
        end
        case (func)
            ooo_pkg::ALU_ADD: return a + b;
            ooo_pkg::ALU_SUB: return a - b;
            ooo_pkg::ALU_AND: return a & b;
            ooo_pkg::ALU_OR:  return a | b;
            ooo_pkg::ALU_XOR: return a ^ b;
            ooo_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:          return '0;
        endcase
    endfunction

    // a tag operand stays a tag only while its producer has not broadcast yet
    task automatic resolve(input bit is_tag, input ooo_pkg::data_t x,
                           output ooo_pkg::operand_t op, output ooo_pkg::data_t v);
        ooo_pkg::prn_t src;
        src = x[5:0];
        v   = is_tag ? exp_val[src] : x;
        if (is_tag && pending[src]) begin
            op.ready = 1'b0;
            op.value = {26'h0, src};
        end else begin
            op.ready = 1'b1;
            op.value = v;
        end
    endtask

    task automatic step();
        @(posedge clock);
        dispatch <= '0;
    endtask

    // model dispatcher, holds back while no credit is left
    task automatic issue_op(input ooo_pkg::fu_type_e fu, input ooo_pkg::alu_func_e func,
                            input bit a_tag, input ooo_pkg::data_t a,
                            input bit b_tag, input ooo_pkg::data_t b, input int dest);
        ooo_pkg::dispatch_packet_t pkt;
        ooo_pkg::operand_t         o1;
        ooo_pkg::operand_t         o2;
        ooo_pkg::data_t            va;
        ooo_pkg::data_t            vb;
        while (available() <= 0) begin
            step();
        end
        @(posedge clock);
        resolve(a_tag, a, o1, va);
        resolve(b_tag, b, o2, vb);
        pkt            = '0;
        pkt.valid      = 1'b1;
        pkt.fu         = fu;
        pkt.func       = func;
        pkt.op1        = o1;
        pkt.op2        = o2;
        pkt.dest_prn   = ooo_pkg::prn_t'(dest);
        pkt.robn       = next_robn;
        exp_val[dest]  = expect_result(fu, func, va, vb);
        exp_robn[dest] = next_robn;
        exp_fu[dest]   = fu;
        pending[dest]  = 1'b1;
        disp_cyc[dest] = cycle + 1;  // cycle that ends with the sampling edge
        rob_tag[next_robn] = ooo_pkg::prn_t'(dest);
        npending++;
        spent++;
        next_robn = next_robn + 5'd1;
        dispatch <= pkt;
    endtask

    task automatic drain();
        while (npending != 0) begin
            step();
        end
        repeat (3) step();
        check_credits("credits", available(), RS_SIZE);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        repeat (6) begin
            @(negedge clock);
            for (int l = 0; l < NUM_CDB; l++) begin
                if (cdb[l].valid !== 1'b0) begin
                    report_error($sformatf("lane %0d valid right after reset", l));
                end
            end
            check_credits("credit_return", int'(credit_return), 0);
        end
        finish_test("reset", e0);
    endtask

    task automatic test_alu();
        int e0;
        e0 = errors;
        for (int f = 0; f < 6; f++) begin
            issue_op(ooo_pkg::FU_ALU, ooo_pkg::alu_func_e'(3'(f)), 1'b0,
                     32'hfff0_1234 + 32'(f), 1'b0, 32'h0000_5a5a, 10 + f);
            drain();
            check_latency(ooo_pkg::prn_t'(10 + f), 2);
            if (arr_lane[10 + f] != 0) begin
                report_error($sformatf("lone alu op used lane %0d", arr_lane[10 + f]));
            end
        end
        finish_test("alu", e0);
    endtask

    task automatic test_mult();
        int e0;
        e0 = errors;
        for (int k = 0; k < 3; k++) begin
            issue_op(ooo_pkg::FU_MULT, ooo_pkg::ALU_ADD, 1'b0,
                     32'h0001_0003 + 32'(k) * 32'h0101_0101,
                     1'b0, 32'h8000_0007 - 32'(k), 20 + k);
        end
        drain();
        for (int k = 0; k < 3; k++) begin
            check_latency(ooo_pkg::prn_t'(20 + k), 1 + ooo_pkg::MULT_STAGES);
            if (k > 0 && arr_cyc[20 + k] != arr_cyc[19 + k] + 1) begin
                report_error("back to back products not in consecutive cycles");
            end
        end
        finish_test("mult", e0);
    endtask

    task automatic test_wakeup();
        int e0;
        e0 = errors;
        issue_op(ooo_pkg::FU_MULT, ooo_pkg::ALU_ADD, 1'b0, 32'h0000_0123, 1'b0, 32'h0004_5678, 30);
        issue_op(ooo_pkg::FU_ALU, ooo_pkg::ALU_ADD, 1'b0, 32'h1000_0000, 1'b1, 32'd30, 31);
        drain();
        if (arr_cyc[31] <= arr_cyc[30]) begin
            report_error("dependent add broadcast before its multiply");
        end
        finish_test("wakeup", e0);
    endtask

    task automatic test_full();
        int e0;
        e0 = errors;
        issue_op(ooo_pkg::FU_MULT, ooo_pkg::ALU_ADD, 1'b0, 32'h0000_0f0f, 1'b0, 32'h0000_1001, 40);
        for (int k = 1; k <= RS_SIZE; k++) begin
            issue_op(ooo_pkg::FU_ALU, ooo_pkg::alu_func_e'(3'(k % 6)), 1'b1, 32'd40,
                     1'b0, 32'(k * 3), 40 + k);
        end
        drain();
        for (int k = 1; k <= RS_SIZE; k++) begin
            if (arr_cyc[40 + k] <= arr_cyc[40]) begin
                report_error($sformatf("tag %0d broadcast before the multiply", 40 + k));
            end
        end
        finish_test("full", e0);
    endtask

    task automatic test_random();
        int                 e0;
        int                 r;
        int                 span;
        ooo_pkg::fu_type_e  fu;
        ooo_pkg::alu_func_e func;
        ooo_pkg::data_t     a;
        ooo_pkg::data_t     b;
        bit                 a_tag;
        bit                 b_tag;
        e0 = errors;
        for (int i = 0; i < 60; i++) begin
            r     = $random(seed);
            fu    = (r[1:0] == 2'b00) ? ooo_pkg::FU_MULT : ooo_pkg::FU_ALU;
            func  = ooo_pkg::alu_func_e'(3'($unsigned($random(seed)) % 6));
            a     = $random(seed);
            b     = $random(seed);
            span  = (i < 8) ? i : 8;  // producers come from the last few ops
            a_tag = (i > 0) && (r[4:2] < 3'd3);
            b_tag = (i > 0) && (r[7:5] < 3'd3);
            if (a_tag) begin
                a = 32'(i - 1 - (int'(r[15:8]) % span));
            end
            if (b_tag) begin
                b = 32'(i - 1 - (int'(r[23:16]) % span));
            end
            issue_op(fu, func, a_tag, a, b_tag, b, i);
        end
        drain();
        finish_test("random", e0);
    endtask

    initial begin
        clock    = 1'b0;
        reset    = 1'b1;
        dispatch = '0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        test_reset();
        test_alu();
        test_mult();
        test_wakeup();
        test_full();
        test_random();
        $display("tests passed: %0d, failed: %0d, errors: %0d", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fu_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_alu (
    input  logic                 clock,
    input  logic                 reset,
    input  ooo_pkg::fu_packet_t  issue,
    output ooo_pkg::cdb_packet_t result
);

    ooo_pkg::data_t alu_out;

    always_comb begin
        case (issue.func)
            ooo_pkg::ALU_ADD: alu_out = issue.op1 + issue.op2;
            ooo_pkg::ALU_SUB: alu_out = issue.op1 - issue.op2;
            ooo_pkg::ALU_AND: alu_out = issue.op1 & issue.op2;
            ooo_pkg::ALU_OR:  alu_out = issue.op1 | issue.op2;
            ooo_pkg::ALU_XOR: alu_out = issue.op1 ^ issue.op2;
            ooo_pkg::ALU_SLT: begin
                alu_out = ooo_pkg::data_t'($signed(issue.op1) < $signed(issue.op2));
            end
            default:          alu_out = '0;  // unused encodings
        endcase
    end

    // one register stage, lane shows the result the cycle after issue
    always_ff @(posedge clock) begin
        result.dest_prn <= issue.dest_prn;
        result.robn     <= issue.robn;
        result.value    <= alu_out;
        if (reset) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= issue.valid;
        end
    end

endmodule

`default_nettype wire

// ==== fu_mult.sv ====
`timescale 1ns/10ps
`default_nettype none

module fu_mult (
    input  logic                 clock,
    input  logic                 reset,
    input  ooo_pkg::fu_packet_t  issue,
    output ooo_pkg::cdb_packet_t result
);

    localparam int LAST = ooo_pkg::MULT_STAGES - 1;

    // pipe[0].value holds the low partial product until stage 1 adds the cross term
    ooo_pkg::cdb_packet_t [LAST:0] pipe;
    logic [15:0]                   pp_cross;  // only the low half of the cross sum matters

    always_ff @(posedge clock) begin
        pipe[0].valid    <= issue.valid;
        pipe[0].dest_prn <= issue.dest_prn;
        pipe[0].robn     <= issue.robn;
        pipe[0].value    <= {16'h0, issue.op1[15:0]} * {16'h0, issue.op2[15:0]};
        pp_cross         <= issue.op1[31:16] * issue.op2[15:0] +
                            issue.op1[15:0] * issue.op2[31:16];

        pipe[1].valid    <= pipe[0].valid;
        pipe[1].dest_prn <= pipe[0].dest_prn;
        pipe[1].robn     <= pipe[0].robn;
        pipe[1].value    <= pipe[0].value + {pp_cross, 16'h0};

        for (int k = 2; k <= LAST; k++) begin
            pipe[k] <= pipe[k-1];  // plain delay stages
        end

        if (reset) begin
            for (int k = 0; k <= LAST; k++) begin
                pipe[k].valid <= 1'b0;
            end
        end
    end

    assign result = pipe[LAST];

    // every accepted multiply leaves on the lane MULT_STAGES cycles later with its low product
    mult_latency: assert property (@(posedge clock) disable iff (reset)
        issue.valid |-> ##(ooo_pkg::MULT_STAGES)
            (result.valid && result.robn == $past(issue.robn, ooo_pkg::MULT_STAGES) &&
             result.value == $past(issue.op1 * issue.op2, ooo_pkg::MULT_STAGES)))
        else $error("fu_mult: result missing, out of order or wrong");

endmodule

`default_nettype wire

// ==== ooo_exec_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module ooo_exec_top #(
    parameter int RS_SIZE  = 8,
    parameter int NUM_ALU  = 2,
    parameter int NUM_MULT = 1,
    localparam int NUM_CDB = NUM_ALU + NUM_MULT,
    localparam int CR_W    = $clog2(NUM_CDB + 1)
) (
    input  logic                                clock,
    input  logic                                reset,
    input  ooo_pkg::dispatch_packet_t           dispatch,
    output logic [CR_W-1:0]                     credit_return,
    output ooo_pkg::cdb_packet_t [NUM_CDB-1:0]  cdb
);

    ooo_pkg::fu_packet_t [NUM_ALU-1:0]  alu_issue;
    ooo_pkg::fu_packet_t [NUM_MULT-1:0] mult_issue;

    // the cdb leaves the top and also feeds the station wakeup
    rs #(
        .RS_SIZE  (RS_SIZE),
        .NUM_ALU  (NUM_ALU),
        .NUM_MULT (NUM_MULT)
    ) u_rs (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .cdb           (cdb),
        .alu_issue     (alu_issue),
        .mult_issue    (mult_issue),
        .credit_return (credit_return)
    );

    // alus own the low lanes
    for (genvar a = 0; a < NUM_ALU; a++) begin : g_alu
        fu_alu u_alu (
            .clock  (clock),
            .reset  (reset),
            .issue  (alu_issue[a]),
            .result (cdb[a])
        );
    end

    for (genvar m = 0; m < NUM_MULT; m++) begin : g_mult
        fu_mult u_mult (
            .clock  (clock),
            .reset  (reset),
            .issue  (mult_issue[m]),
            .result (cdb[NUM_ALU + m])   // lanes after the alus
        );
    end

endmodule

`default_nettype wire

// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    typedef logic [31:0] data_t;
    typedef logic [5:0]  prn_t;   // physical register tag
    typedef logic [4:0]  robn_t;  // passed through untouched for retirement

    localparam int MULT_STAGES = 3;

    typedef enum logic {
        FU_ALU,
        FU_MULT
    } fu_type_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT   // signed compare, 1 or 0
    } alu_func_e;

    // value when ready, otherwise the producer tag in the low bits
    typedef struct packed {
        logic  ready;
        data_t value;
    } operand_t;

    typedef struct packed {
        logic      valid;
        fu_type_e  fu;
        alu_func_e func;      // don't care for multiplies
        operand_t  op1;
        operand_t  op2;
        prn_t      dest_prn;
        robn_t     robn;
    } dispatch_packet_t;

    // same layout as the dispatch packet, valid marks an occupied slot
    typedef struct packed {
        logic      valid;
        fu_type_e  fu;
        alu_func_e func;
        operand_t  op1;
        operand_t  op2;
        prn_t      dest_prn;
        robn_t     robn;
    } rs_entry_t;

    typedef struct packed {
        logic      valid;
        alu_func_e func;
        data_t     op1;
        data_t     op2;
        prn_t      dest_prn;
        robn_t     robn;
    } fu_packet_t;

    typedef struct packed {
        logic  valid;
        prn_t  dest_prn;
        robn_t robn;
        data_t value;
    } cdb_packet_t;

endpackage

`default_nettype wire

// ==== psel_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]            req,
    output logic [WIDTH-1:0]            gnt,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus
);

    logic overlap;

    // peel off the lowest remaining request once per slice
    always_comb begin
        logic [WIDTH-1:0] left;
        left = req;
        gnt  = '0;
        for (int k = 0; k < REQS; k++) begin
            gnt_bus[k] = left & (~left + WIDTH'(1));  // isolate lowest set bit
            left       = left & ~gnt_bus[k];
            gnt        = gnt | gnt_bus[k];
        end
    end

    always_comb begin
        overlap = 1'b0;
        for (int i = 0; i < REQS; i++) begin
            for (int j = i + 1; j < REQS; j++) begin
                overlap = overlap | (|(gnt_bus[i] & gnt_bus[j]));
            end
        end
    end

    // one request never reaches two units
    always_comb begin
        assert final (!overlap)
            else $error("psel_gen: two grant slices share a request bit");
    end

endmodule

`default_nettype wire

// ==== rs.sv ====
`timescale 1ns/10ps
`default_nettype none

module rs #(
    parameter int RS_SIZE  = 8,
    parameter int NUM_ALU  = 2,
    parameter int NUM_MULT = 1,
    localparam int NUM_CDB = NUM_ALU + NUM_MULT,
    localparam int CR_W    = $clog2(NUM_CDB + 1)
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  ooo_pkg::dispatch_packet_t             dispatch,
    input  ooo_pkg::cdb_packet_t [NUM_CDB-1:0]    cdb,
    output ooo_pkg::fu_packet_t  [NUM_ALU-1:0]    alu_issue,
    output ooo_pkg::fu_packet_t  [NUM_MULT-1:0]   mult_issue,
    output logic [CR_W-1:0]                       credit_return
);

    ooo_pkg::rs_entry_t [RS_SIZE-1:0] entries;
    ooo_pkg::rs_entry_t [RS_SIZE-1:0] next_entries;

    logic [RS_SIZE-1:0] occupied;
    logic [RS_SIZE-1:0] alu_req;
    logic [RS_SIZE-1:0] mult_req;
    logic [RS_SIZE-1:0] alu_gnt;
    logic [RS_SIZE-1:0] mult_gnt;
    logic [RS_SIZE-1:0] issue_gnt;
    logic [NUM_ALU-1:0][RS_SIZE-1:0]  alu_gnt_bus;
    logic [NUM_MULT-1:0][RS_SIZE-1:0] mult_gnt_bus;

    // swap a waiting tag for the value if any lane broadcasts it
    function automatic ooo_pkg::operand_t wake(
        input ooo_pkg::operand_t                 op,
        input ooo_pkg::cdb_packet_t [NUM_CDB-1:0] bus
    );
        ooo_pkg::operand_t res;
        res = op;
        for (int l = 0; l < NUM_CDB; l++) begin
            if (!res.ready && bus[l].valid &&
                bus[l].dest_prn == res.value[$bits(ooo_pkg::prn_t)-1:0]) begin
                res.ready = 1'b1;
                res.value = bus[l].value;
            end
        end
        return res;
    endfunction

    function automatic ooo_pkg::fu_packet_t to_fu(input ooo_pkg::rs_entry_t e);
        ooo_pkg::fu_packet_t p;
        p.valid    = 1'b1;
        p.func     = e.func;
        p.op1      = e.op1.value;
        p.op2      = e.op2.value;
        p.dest_prn = e.dest_prn;
        p.robn     = e.robn;
        return p;
    endfunction

    always_comb begin
        logic ready;
        for (int i = 0; i < RS_SIZE; i++) begin
            ready       = entries[i].valid && entries[i].op1.ready && entries[i].op2.ready;
            occupied[i] = entries[i].valid;
            alu_req[i]  = ready && (entries[i].fu == ooo_pkg::FU_ALU);
            mult_req[i] = ready && (entries[i].fu == ooo_pkg::FU_MULT);
        end
    end

    psel_gen #(
        .WIDTH (RS_SIZE),
        .REQS  (NUM_ALU)
    ) alu_sel (
        .req     (alu_req),
        .gnt     (alu_gnt),
        .gnt_bus (alu_gnt_bus)
    );

    psel_gen #(
        .WIDTH (RS_SIZE),
        .REQS  (NUM_MULT)
    ) mult_sel (
        .req     (mult_req),
        .gnt     (mult_gnt),
        .gnt_bus (mult_gnt_bus)
    );

    assign issue_gnt = alu_gnt | mult_gnt;

    // grant slices are one-hot, so at most one entry lands on each port
    always_comb begin
        for (int k = 0; k < NUM_ALU; k++) begin
            alu_issue[k] = '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                if (alu_gnt_bus[k][i]) begin
                    alu_issue[k] = to_fu(entries[i]);
                end
            end
        end
        for (int k = 0; k < NUM_MULT; k++) begin
            mult_issue[k] = '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                if (mult_gnt_bus[k][i]) begin
                    mult_issue[k] = to_fu(entries[i]);
                end
            end
        end
    end

    always_comb begin
        ooo_pkg::rs_entry_t incoming;
        logic               placed;
        next_entries = entries;
        placed       = 1'b0;

        // incoming ops can catch a broadcast in the same cycle
        incoming     = ooo_pkg::rs_entry_t'(dispatch);
        incoming.op1 = wake(dispatch.op1, cdb);
        incoming.op2 = wake(dispatch.op2, cdb);

        for (int i = 0; i < RS_SIZE; i++) begin
            if (issue_gnt[i]) begin
                next_entries[i].valid = 1'b0;
            end
            if (next_entries[i].valid) begin
                next_entries[i].op1 = wake(entries[i].op1, cdb);
                next_entries[i].op2 = wake(entries[i].op2, cdb);
            end
        end

        // slots issuing now are not reused until the next cycle
        for (int i = 0; i < RS_SIZE; i++) begin
            if (dispatch.valid && !placed && !entries[i].valid) begin
                next_entries[i] = incoming;
                placed          = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        entries <= next_entries;
        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
            credit_return <= '0;
        end else begin
            credit_return <= CR_W'($countones(issue_gnt));  // one credit per issue
        end
    end

    // dispatcher ran out of credits if this fires
    no_dispatch_when_full: assert property (@(posedge clock) disable iff (reset)
        dispatch.valid |-> !(&occupied))
        else $error("rs: dispatch arrived with every entry occupied");

    // an entry issued last cycle was freed and cannot go out again
    freed_not_issued: assert property (@(posedge clock) disable iff (reset)
        (issue_gnt != '0) |=> ((issue_gnt & $past(issue_gnt)) == '0))
        else $error("rs: freed entry issued a second time");

endmodule

`default_nettype wire

// ==== sources.f ====
ooo_pkg.sv
psel_gen.sv
rs.sv
fu_alu.sv
fu_mult.sv
ooo_exec_top.sv
exec_tb.sv
